// ==== flist.f ====
+incdir+src
src/vseq_pkg.sv
src/vid_tracker.sv
src/reg_scoreboard.sv
src/unit_credit.sv
src/issue_ctrl.sv
src/vseq_top.sv
tests/tb_vseq.sv

// ==== run.sh ====
#!/bin/sh
# Build the vector sequencer testbench with Verilator and run it
verilator --binary -f flist.f --top-module tb_vseq -o tb_vseq && \
  ./obj_dir/tb_vseq | tee /dev/stderr | grep -qF ">>> PASS" && \
  echo "simulation passed" || \
  { echo "simulation failed"; exit 1; }

// ==== src/issue_ctrl.sv ====
// Issue control
// Decides when a dispatcher request can issue, builds the processing unit
// request and holds it until the target unit accepts it

`include "vseq_consts.svh"

module issue_ctrl import vseq_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Dispatcher side
  input  seq_req_t                    req_i,
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  // State of the other sequencer blocks
  input  vid_t                        next_vid_i,
  input  logic                        id_full_i,
  input  logic [`VSEQ_NR_UNITS-1:0]   queue_ready_i,
  input  vid_mask_t                   hazard_i,
  // Processing unit side
  input  logic [`VSEQ_NR_UNITS-1:0]   pe_ready_i,
  output pe_req_t                     pe_req_o,
  output logic                        pe_req_valid_o,
  // Issue strobe for the bookkeeping blocks
  output logic                        issue_o,
  output vid_t                        issue_vid_o,
  output unit_e                       issue_unit_o
);

  logic unit_ok;
  logic pe_xfer;
  logic slot_free;

  // Unit codes above the last unit never find a free queue
  assign unit_ok   = (req_i.unit < unit_e'(`VSEQ_NR_UNITS)) && queue_ready_i[req_i.unit];

  // The held request leaves when its own unit takes it
  assign pe_xfer   = pe_req_valid_o && pe_ready_i[pe_req_o.unit];
  assign slot_free = !pe_req_valid_o || pe_xfer;

  // Hazards never stall, they travel with the instruction for chaining
  assign issue_o      = req_valid_i && !id_full_i && unit_ok && slot_free;
  assign req_ready_o  = issue_o;
  assign issue_vid_o  = next_vid_i;
  assign issue_unit_o = req_i.unit;

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid_ff
    if (!rst_ni) begin
      pe_req_valid_o <= 1'b0;
    end else if (issue_o) begin
      pe_req_valid_o <= 1'b1;
    end else if (pe_xfer) begin
      pe_req_valid_o <= 1'b0;
    end
  end : p_valid_ff

  // Request fields only load on issue and stay put under back-pressure
  always_ff @(posedge clk_i) begin : p_req_ff
    if (issue_o) begin
      pe_req_o <= '{
        id    : next_vid_i,
        unit  : req_i.unit,
        vs1   : req_i.vs1,
        vs2   : req_i.vs2,
        vd    : req_i.vd,
        vl    : req_i.vl,
        hazard: hazard_i
      };
    end
  end : p_req_ff

endmodule : issue_ctrl

// ==== src/reg_scoreboard.sv ====
// Vector register scoreboard
// Tracks the last writer and last reader of every vector register and
// builds the RAW, WAR and WAW hazard vector of the incoming request

`include "vseq_consts.svh"

module reg_scoreboard import vseq_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Request under consideration
  input  seq_req_t  req_i,
  input  vid_mask_t running_i,
  // Issue of that request
  input  logic      issue_i,
  input  vid_t      issue_vid_i,
  // IDs the request depends on
  output vid_mask_t hazard_o
);

  vreg_entry_t [`VSEQ_NR_VREGS-1:0] wr_list_d, wr_list_q;
  vreg_entry_t [`VSEQ_NR_VREGS-1:0] rd_list_d, rd_list_q;

  // List entries after dropping the ones whose instruction has finished
  vreg_entry_t [`VSEQ_NR_VREGS-1:0] wr_live, rd_live;

  // One-hot bit for the ID of a live entry, all zero otherwise
  function automatic vid_mask_t entry_bit(vreg_entry_t entry);
    vid_mask_t mask;
    mask            = '0;
    mask[entry.vid] = entry.valid;
    return mask;
  endfunction : entry_bit

  //////////////////////////////////////////////////
  // Live view of the access lists
  //////////////////////////////////////////////////

  always_comb begin : p_live
    for (int unsigned r = 0; r < `VSEQ_NR_VREGS; r++) begin
      wr_live[r]       = wr_list_q[r];
      wr_live[r].valid = wr_list_q[r].valid & running_i[wr_list_q[r].vid];
      rd_live[r]       = rd_list_q[r];
      rd_live[r].valid = rd_list_q[r].valid & running_i[rd_list_q[r].vid];
    end
  end : p_live

  //////////////////////////////////////////////////
  // Hazard vector
  //////////////////////////////////////////////////

  always_comb begin : p_hazard
    hazard_o = '0;
    // RAW on the source operands
    if (req_i.use_vs1) hazard_o |= entry_bit(wr_live[req_i.vs1]);
    if (req_i.use_vs2) hazard_o |= entry_bit(wr_live[req_i.vs2]);
    // WAR and WAW on the destination
    if (req_i.use_vd) begin
      hazard_o |= entry_bit(rd_live[req_i.vd]);
      hazard_o |= entry_bit(wr_live[req_i.vd]);
    end
  end : p_hazard

  //////////////////////////////////////////////////
  // List update
  //////////////////////////////////////////////////

  // Dead entries are dropped so a reused ID never inherits stale accesses
  always_comb begin : p_update
    wr_list_d = wr_live;
    rd_list_d = rd_live;
    if (issue_i) begin
      if (req_i.use_vd)  wr_list_d[req_i.vd]  = '{valid: 1'b1, vid: issue_vid_i};
      if (req_i.use_vs1) rd_list_d[req_i.vs1] = '{valid: 1'b1, vid: issue_vid_i};
      if (req_i.use_vs2) rd_list_d[req_i.vs2] = '{valid: 1'b1, vid: issue_vid_i};
    end
  end : p_update

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_lists_ff
    if (!rst_ni) begin
      wr_list_q <= '0;
      rd_list_q <= '0;
    end else begin
      wr_list_q <= wr_list_d;
      rd_list_q <= rd_list_d;
    end
  end : p_lists_ff

endmodule : reg_scoreboard

// ==== src/unit_credit.sv ====
// Unit queue credits
// Counts the instructions outstanding at each processing unit and flags
// the units whose queue still has room

`include "vseq_consts.svh"

module unit_credit import vseq_pkg::*; (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Issue towards one unit
  input  logic                             issue_i,
  input  unit_e                            issue_unit_i,
  // Completion reports of all units
  input  unit_done_t [`VSEQ_NR_UNITS-1:0]  unit_done_i,
  // Room left in each unit queue
  output logic       [`VSEQ_NR_UNITS-1:0]  queue_ready_o
);

  // Enough bits to hold a full queue
  localparam int unsigned CntW = $clog2(`VSEQ_QUEUE_DEPTH + 1);

  for (genvar u = 0; u < `VSEQ_NR_UNITS; u++) begin : gen_unit_cnt
    logic            cnt_up;
    logic            cnt_down;
    logic [CntW-1:0] cnt_q;

    // An issue to this unit takes a slot, its done report returns one
    assign cnt_up   = issue_i && (issue_unit_i == unit_e'(u));
    assign cnt_down = unit_done_i[u].valid;

    // Both in one cycle leave the count as it is
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_cnt_ff
      if (!rst_ni) begin
        cnt_q <= '0;
      end else if (cnt_up && !cnt_down) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (cnt_down && !cnt_up) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end : p_cnt_ff

    assign queue_ready_o[u] = cnt_q < CntW'(`VSEQ_QUEUE_DEPTH);
  end : gen_unit_cnt

endmodule : unit_credit

// ==== src/vid_tracker.sv ====
// Instruction ID tracker
// Keeps the bitmap of running instruction IDs, hands out the lowest free
// ID and reports when the sequencer has nothing in flight

`include "vseq_consts.svh"

module vid_tracker import vseq_pkg::*; (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Issue of a new instruction
  input  logic                             issue_i,
  input  vid_t                             issue_vid_i,
  // Completion reports of all units
  input  unit_done_t [`VSEQ_NR_UNITS-1:0]  unit_done_i,
  // Tracking state
  output vid_mask_t                        running_o,
  output vid_t                             next_vid_o,
  output logic                             full_o,
  output logic                             idle_o
);

  vid_mask_t running_d, running_q;

  // Clear finished IDs first, then mark the newly issued one
  // A done and an issue never name the same ID in one cycle
  always_comb begin : p_running
    running_d = running_q;
    for (int unsigned u = 0; u < `VSEQ_NR_UNITS; u++) begin
      if (unit_done_i[u].valid) begin
        running_d[unit_done_i[u].vid] = 1'b0;
      end
    end
    if (issue_i) begin
      running_d[issue_vid_i] = 1'b1;
    end
  end : p_running

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_running_ff
    if (!rst_ni) begin
      running_q <= '0;
    end else begin
      running_q <= running_d;
    end
  end : p_running_ff

  // Scan from the top so that the lowest clear bit wins
  always_comb begin : p_next_vid
    next_vid_o = '0;
    for (int i = `VSEQ_NR_VINSN - 1; i >= 0; i--) begin
      if (!running_q[i]) begin
        next_vid_o = vid_t'(i);
      end
    end
  end : p_next_vid

  assign full_o    = &running_q;
  assign idle_o    = ~|running_q;
  assign running_o = running_q;

endmodule : vid_tracker

// ==== src/vseq_consts.svh ====
// Vector sequencer constants
// Sizes of the ID space, the vector register file, the set of processing
// units and the per-unit instruction queues

`ifndef VSEQ_CONSTS_SVH
`define VSEQ_CONSTS_SVH

//////////////////////////////////////////////////
// Instruction tracking
//////////////////////////////////////////////////

// Number of instruction IDs that can be in flight at once
`define VSEQ_NR_VINSN 8

// Architectural vector registers v0 to v31
`define VSEQ_NR_VREGS 32

//////////////////////////////////////////////////
// Processing units
//////////////////////////////////////////////////

// Arithmetic, load and store units
`define VSEQ_NR_UNITS 3

// Outstanding instructions a unit queue can hold
`define VSEQ_QUEUE_DEPTH 2

// Width of the vector length field
`define VSEQ_VL_W 8

`endif

// ==== src/vseq_pkg.sv ====
// Vector sequencer types
// Request formats on the dispatcher and processing unit sides, unit
// completion reports and the register access list entries

package vseq_pkg;

  `include "vseq_consts.svh"

  // Instruction ID and the one-hot or bitmap form of a set of IDs
  typedef logic [$clog2(`VSEQ_NR_VINSN)-1:0] vid_t;
  typedef logic [`VSEQ_NR_VINSN-1:0]         vid_mask_t;

  // Vector register index
  typedef logic [$clog2(`VSEQ_NR_VREGS)-1:0] vreg_t;

  // Processing unit that executes an instruction
  typedef enum logic [1:0] {
    UNIT_ALU   = 2'd0,
    UNIT_LOAD  = 2'd1,
    UNIT_STORE = 2'd2
  } unit_e;

  // Decoded instruction as it comes from the dispatcher
  typedef struct packed {
    unit_e                  unit;
    vreg_t                  vs1;
    logic                   use_vs1;
    vreg_t                  vs2;
    logic                   use_vs2;
    vreg_t                  vd;
    logic                   use_vd;
    logic [`VSEQ_VL_W-1:0]  vl;
  } seq_req_t;

  // Instruction as issued to a processing unit, with its ID and the IDs
  // it must chain behind
  typedef struct packed {
    vid_t                   id;
    unit_e                  unit;
    vreg_t                  vs1;
    vreg_t                  vs2;
    vreg_t                  vd;
    logic [`VSEQ_VL_W-1:0]  vl;
    vid_mask_t              hazard;
  } pe_req_t;

  // One-cycle completion report of a unit
  typedef struct packed {
    logic valid;
    vid_t vid;
  } unit_done_t;

  // Last reader or writer of a vector register
  typedef struct packed {
    logic valid;
    vid_t vid;
  } vreg_entry_t;

endpackage : vseq_pkg

// ==== src/vseq_top.sv ====
// Vector sequencer top level
// Connects ID tracking, the register scoreboard, the unit credits and the
// issue register between the dispatcher and the processing units

`include "vseq_consts.svh"

module vseq_top import vseq_pkg::*; (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Dispatcher
  input  seq_req_t                         req_i,
  input  logic                             req_valid_i,
  output logic                             req_ready_o,
  // Processing units
  output pe_req_t                          pe_req_o,
  output logic                             pe_req_valid_o,
  input  logic       [`VSEQ_NR_UNITS-1:0]  pe_ready_i,
  input  unit_done_t [`VSEQ_NR_UNITS-1:0]  unit_done_i,
  // Status
  output logic                             idle_o
);

  vid_mask_t                   running;
  vid_t                        next_vid;
  logic                        id_full;
  vid_mask_t                   hazard;
  logic [`VSEQ_NR_UNITS-1:0]   queue_ready;
  logic                        issue;
  vid_t                        issue_vid;
  unit_e                       issue_unit;

  vid_tracker i_vid_tracker (
    .clk_i      (clk_i      ),
    .rst_ni     (rst_ni     ),
    .issue_i    (issue      ),
    .issue_vid_i(issue_vid  ),
    .unit_done_i(unit_done_i),
    .running_o  (running    ),
    .next_vid_o (next_vid   ),
    .full_o     (id_full    ),
    .idle_o     (idle_o     )
  );

  reg_scoreboard i_reg_scoreboard (
    .clk_i      (clk_i    ),
    .rst_ni     (rst_ni   ),
    .req_i      (req_i    ),
    .running_i  (running  ),
    .issue_i    (issue    ),
    .issue_vid_i(issue_vid),
    .hazard_o   (hazard   )
  );

  unit_credit i_unit_credit (
    .clk_i        (clk_i      ),
    .rst_ni       (rst_ni     ),
    .issue_i      (issue      ),
    .issue_unit_i (issue_unit ),
    .unit_done_i  (unit_done_i),
    .queue_ready_o(queue_ready)
  );

  issue_ctrl i_issue_ctrl (
    .clk_i         (clk_i         ),
    .rst_ni        (rst_ni        ),
    .req_i         (req_i         ),
    .req_valid_i   (req_valid_i   ),
    .req_ready_o   (req_ready_o   ),
    .next_vid_i    (next_vid      ),
    .id_full_i     (id_full       ),
    .queue_ready_i (queue_ready   ),
    .hazard_i      (hazard        ),
    .pe_ready_i    (pe_ready_i    ),
    .pe_req_o      (pe_req_o      ),
    .pe_req_valid_o(pe_req_valid_o),
    .issue_o       (issue         ),
    .issue_vid_o   (issue_vid     ),
    .issue_unit_o  (issue_unit    )
  );

endmodule : vseq_top

// ==== tests/seq_vectors.txt ====
// Hex digits from the left: kind(1 req 2 done) unit vs1[2] vs2[2] vd[2] use(4 vs1 2 vs2 1 vd)
// vl[2] id hazard[2] stall blocked rel_unit rel_vid idle 0
// IDs 0, 1, 2 in order, RAW on the load result, PE stall on the store
1001020370a000000000
11000004114100000000
12040000408202300000
// ID 1 comes back and is reused, RAW and WAW on v3
21000000000100000000
10030603710101000000
20000000000000000000
// WAR on v6, the finished load no longer counts
10010406720002000000
1203000640c302000000
// Third load waits for a load credit
11000008110400000000
11000009110500000000
1100000a110400041400
22000000000200000000
12090a00604230200000
// Drain everything back to idle
20000000000100000000
20000000000000000000
21000000000500000000
22000000000300000000
21000000000400000000
22000000000200000010
1003090a701000000000
20000000000000000010

// ==== tests/tb_vseq.sv ====
// Vector sequencer testbench
// Replays request and completion lines from a vector file and checks
// issued IDs, hazard vectors, unit and PE back-pressure and the idle flag

`include "vseq_consts.svh"

module tb_vseq import vseq_pkg::*; ();

  localparam int MaxLines      = 64;
  localparam int CyclesPerLine = 40;
  localparam int ResetCycles   = 16;

  logic                             clk_i;
  logic                             rst_ni;
  seq_req_t                         req_i;
  logic                             req_valid_i;
  logic                             req_ready_o;
  pe_req_t                          pe_req_o;
  logic                             pe_req_valid_o;
  logic       [`VSEQ_NR_UNITS-1:0]  pe_ready_i;
  unit_done_t [`VSEQ_NR_UNITS-1:0]  unit_done_i;
  logic                             idle_o;

  // Vector lines as loaded, in the column layout given at the top of the file
  logic [79:0] vectors [MaxLines];
  int          n_lines;
  int          errors;
  int          failed_tests;
  int          cycle_cnt   = 0;
  int          cycle_limit = 0;
  integer      seed        = 32'h46be;

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end : clock_gen

  vseq_top i_vseq_top (
    .clk_i         (clk_i         ),
    .rst_ni        (rst_ni        ),
    .req_i         (req_i         ),
    .req_valid_i   (req_valid_i   ),
    .req_ready_o   (req_ready_o   ),
    .pe_req_o      (pe_req_o      ),
    .pe_req_valid_o(pe_req_valid_o),
    .pe_ready_i    (pe_ready_i    ),
    .unit_done_i   (unit_done_i   ),
    .idle_o        (idle_o        )
  );

  // Ends a run that stops making progress
  always @(posedge clk_i) begin : watchdog
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display(">>> FAIL");
      $finish;
    end
  end : watchdog

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] got);
    $display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
    errors++;
  endtask

  //////////////////////////////////////////////////
  // Line handlers that start and end on a falling edge
  //////////////////////////////////////////////////

  task automatic run_request(input logic [79:0] v);
    seq_req_t req;
    pe_req_t  exp;
    int       stall;
    int       blk;
    req.unit    = unit_e'(v[73:72]);
    req.vs1     = v[68:64];
    req.vs2     = v[60:56];
    req.vd      = v[52:48];
    req.use_vs1 = v[46];
    req.use_vs2 = v[45];
    req.use_vd  = v[44];
    req.vl      = v[43:36];
    // The issued request carries the operands unchanged plus ID and hazards
    exp.id      = v[34:32];
    exp.unit    = req.unit;
    exp.vs1     = req.vs1;
    exp.vs2     = req.vs2;
    exp.vd      = req.vd;
    exp.vl      = req.vl;
    exp.hazard  = v[31:24];
    stall       = int'(v[23:20]);
    blk         = int'(v[19:16]);
    req_i       = req;
    req_valid_i = 1'b1;
    pe_ready_i  = '1;
    // A full unit queue keeps the request waiting at the dispatcher
    for (int b = 0; b < blk; b++) begin
      @(negedge clk_i);
      if (req_ready_o !== 1'b0) report_mismatch("req_ready_o", 64'(0), 64'(req_ready_o));
      if (pe_req_valid_o !== 1'b0) begin
        report_mismatch("pe_req_valid_o", 64'(0), 64'(pe_req_valid_o));
      end
    end
    if (blk > 0) begin
      unit_done_i[v[13:12]] = '{valid: 1'b1, vid: v[10:8]};
      @(negedge clk_i);
      unit_done_i = '0;
    end
    // The PE request turns valid right after the handshake
    do begin
      @(negedge clk_i);
    end while (!pe_req_valid_o);
    if (pe_req_o !== exp) report_mismatch("pe_req_o", 64'(exp), 64'(pe_req_o));
    // The request stays offered while the unit stalls, so a second accept would show
    if (stall > 0) begin
      pe_ready_i = '0;
      for (int s = 0; s < stall; s++) begin
        @(negedge clk_i);
        if (pe_req_valid_o !== 1'b1) begin
          report_mismatch("pe_req_valid_o", 64'(1), 64'(pe_req_valid_o));
        end
        if (pe_req_o !== exp) report_mismatch("pe_req_o", 64'(exp), 64'(pe_req_o));
        if (req_ready_o !== 1'b0) report_mismatch("req_ready_o", 64'(0), 64'(req_ready_o));
      end
    end
    req_valid_i = 1'b0;
    pe_ready_i  = '1;
    @(negedge clk_i);
    if (pe_req_valid_o !== 1'b0) begin
      $display("error at %0t: the PE request was not taken by its unit", $time);
      errors++;
    end
  endtask

  task automatic pulse_done(input logic [79:0] v);
    unit_done_i[v[73:72]] = '{valid: 1'b1, vid: v[34:32]};
    @(negedge clk_i);
    unit_done_i = '0;
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin : main
    int errs_before;
    int gap;
    rst_ni       = 1'b0;
    req_i        = '0;
    req_valid_i  = 1'b0;
    pe_ready_i   = '1;
    unit_done_i  = '0;
    errors       = 0;
    failed_tests = 0;
    // Unloaded entries keep kind 0 and so end the list
    for (int i = 0; i < MaxLines; i++) begin
      vectors[i] = 80'(i);
    end
    $readmemh("tests/seq_vectors.txt", vectors);
    n_lines = 0;
    while (n_lines < MaxLines && vectors[n_lines][79:76] != 4'h0) begin
      n_lines++;
    end
    cycle_limit = ResetCycles + CyclesPerLine * (n_lines + 1);
    if (n_lines == 0) begin
      $display("error: no vector lines were loaded");
      errors++;
    end

    repeat (ResetCycles) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    errs_before = errors;
    if (idle_o !== 1'b1) report_mismatch("idle_o", 64'(1), 64'(idle_o));
    if (req_ready_o !== 1'b0) report_mismatch("req_ready_o", 64'(0), 64'(req_ready_o));
    if (pe_req_valid_o !== 1'b0) begin
      report_mismatch("pe_req_valid_o", 64'(0), 64'(pe_req_valid_o));
    end
    if (errors != errs_before) failed_tests++;
    $display("test 0 reset state: %s", (errors == errs_before) ? "ok" : "failed");

    for (int i = 0; i < n_lines; i++) begin
      errs_before = errors;
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) @(negedge clk_i);
      if (vectors[i][79:76] == 4'h1) begin
        run_request(vectors[i]);
      end else if (vectors[i][79:76] == 4'h2) begin
        pulse_done(vectors[i]);
      end else begin
        $display("error: vector line %0d has an unknown kind", i + 1);
        errors++;
      end
      if (idle_o !== vectors[i][4]) begin
        report_mismatch("idle_o", 64'(vectors[i][4]), 64'(idle_o));
      end
      if (errors != errs_before) failed_tests++;
      $display("test %0d %s unit %0d id %0d: %s", i + 1,
               (vectors[i][79:76] == 4'h1) ? "request" : "done",
               vectors[i][73:72], vectors[i][34:32],
               (errors == errs_before) ? "ok" : "failed");
    end

    $display("%0d tests run, %0d failed, %0d errors", n_lines + 1, failed_tests, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end : main

endmodule : tb_vseq
